// ==== Bender.yml ====
package:
  name: core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/core_pkg.sv
      - design/decode.sv
      - design/execute.sv
      - design/result.sv
      - design/core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/core_properties.sv
      - bench/core_tb.sv

// ==== bench/core_properties.sv ====
// Core pipeline assertions
`timescale 1ns/1ps
`include "core_consts.svh"

module core_properties (
    input logic                        clk,
    input logic                        reset,
    input logic                        instrValid,
    input logic                        retireValid,
    input logic                        err,
    input logic [`CORE_DATA_WIDTH-1:0] retireCount
);

    // One slot retires or faults, never both
    noDoubleStrobe: assert property (@(posedge clk) disable iff (reset)
        !(retireValid && err))
        else $error("retireValid and err high in the same cycle");

    quietAfterReset: assert property (@(posedge clk) reset |=> !retireValid && !err)
        else $error("retire or err strobe in the cycle after reset");

    // Two-stage latency from strobe to retire slot
    strobeFollowsIssue: assert property (@(posedge clk) disable iff (reset)
        (retireValid || err) |-> $past(instrValid, 2))
        else $error("retire slot without an instruction strobe two cycles earlier");

    countFollowsRetire: assert property (@(posedge clk) disable iff (reset)
        $changed(retireCount) |-> $past(retireValid))
        else $error("retireCount changed without a retire in the cycle before");

endmodule

bind core core_properties props (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .retireValid(retireValid),
    .err(err),
    .retireCount(retireCount)
);

// ==== bench/core_tb.sv ====
// Core testbench
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;

    localparam int randomSlots = 300;
    // Strobe and gap cycles of all directed tests plus the random run
    localparam int issuedSlots = 8 + 120 + 16 + 16 + 48 + randomSlots;
    localparam int cycleLimit = 2 * issuedSlots + 50;

    logic                        clk;
    logic                        reset;
    core_pkg::coreInstr          instr;
    logic                        instrValid;
    logic                        retireValid;
    logic [`CORE_REG_BITS-1:0]   retireReg;
    logic [`CORE_DATA_WIDTH-1:0] retireData;
    logic                        err;
    logic [`CORE_DATA_WIDTH-1:0] retireCount;

    logic [31:0]                 lfsrState;
    logic [`CORE_DATA_WIDTH-1:0] modelRegs [`CORE_REG_COUNT];
    logic [1:0]                  expKind [$];
    logic [`CORE_REG_BITS-1:0]   expReg [$];
    logic [`CORE_DATA_WIDTH-1:0] expData [$];
    string                       expTest [$];
    int legalIssued = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;

    core dut (.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
        .err(err), .retireCount(retireCount));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic int takeBits(input int count);
        int value;
        int k;
        logic fb;
        value = 0;
        for (k = 0; k < count; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value = (value << 1) | fb;
        end
        return value;
    endfunction

    function automatic int legalOp(input int idx);
        return (idx < 7) ? idx : idx + 1;
    endfunction

    function automatic int illegalOp(input int idx);
        return (idx == 0) ? 7 : idx + 10;
    endfunction

    // About one in eight is illegal
    function automatic int randomOp();
        if (takeBits(3) == 0) begin
            return illegalOp(takeBits(3) % 6);
        end
        return legalOp(takeBits(4) % 10);
    endfunction

    function automatic logic [`CORE_DATA_WIDTH-1:0] modelOp(input int op,
            input logic [`CORE_DATA_WIDTH-1:0] a, input logic [`CORE_DATA_WIDTH-1:0] b,
            input logic [`CORE_IMM_BITS-1:0] imm);
        logic [`CORE_DATA_WIDTH-1:0] immExt;
        immExt = {{(`CORE_DATA_WIDTH - `CORE_IMM_BITS){imm[`CORE_IMM_BITS-1]}}, imm};
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[3:0];
            6: return a >> b[3:0];
            8: return a + immExt;
            9: return a ^ immExt;
            default: return immExt;
        endcase
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     testName, field, expected, actual);
        end
    endtask

    // Strobe one word and update the model in issue order
    task automatic issue(input int op, input int rd, input int rs, input int rt,
                         input int imm, input string testName);
        core_pkg::coreInstr          word;
        logic [`CORE_DATA_WIDTH-1:0] value;
        word = '0;
        if (op >= 8 && op <= 10) begin
            word.i.opcode = core_pkg::coreOp'(op[3:0]);
            word.i.rd = rd[2:0];
            word.i.rs = rs[2:0];
            word.i.imm = imm[5:0];
        end else begin
            word.r.opcode = core_pkg::coreOp'(op[3:0]);
            word.r.rd = rd[2:0];
            word.r.rs = rs[2:0];
            word.r.rt = rt[2:0];
        end
        @(posedge clk);
        instr <= word;
        instrValid <= 1'b1;
        expTest.push_back(testName);
        expReg.push_back(rd[2:0]);
        if (op <= 6 || (op >= 8 && op <= 10)) begin
            value = modelOp(op, modelRegs[rs], modelRegs[rt], imm[5:0]);
            modelRegs[rd] = value;
            legalIssued++;
            expKind.push_back(2'b10);
            expData.push_back(value);
        end else begin
            expKind.push_back(2'b01);
            expData.push_back('0);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instrValid <= 1'b0;
        end
    endtask

    task automatic waitDrain();
        idle(1);
        while (expKind.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic finishTest(input string name, input int checksBefore, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("%s done: %0d checks, %0d errors", name, checkCount - checksBefore,
                 errorCount - errorsBefore);
    endtask

    // Every retire or err slot pops one expected outcome
    always @(negedge clk) begin : retireCheck
        logic [1:0] kind;
        string      testName;
        if (!reset && (retireValid || err)) begin
            if (expKind.size() == 0) begin
                errorCount++;
                $display("ERROR: retire slot seen with no instruction in flight");
            end else begin
                kind = expKind.pop_front();
                testName = expTest.pop_front();
                checkValue(testName, "kind", kind, {retireValid, err});
                if (kind == 2'b10) begin
                    checkValue(testName, "reg", expReg[0], retireReg);
                    checkValue(testName, "data", expData[0], retireData);
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("ERROR: run did not finish within %0d cycles", cycleLimit);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        int k;
        int c0;
        int e0;
        int rd;
        int other;
        int prevRd;
        reset = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        lfsrState = 32'h091d0b9b;
        for (k = 0; k < `CORE_REG_COUNT; k++) begin
            modelRegs[k] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // OR of each register with r0 right after reset
        c0 = checkCount;
        e0 = errorCount;
        @(negedge clk);
        checkValue("reset state", "retireCount", 0, retireCount);
        for (k = 0; k < `CORE_REG_COUNT; k++) begin
            issue(3, k, k, 0, 0, "reset state");
        end
        waitDrain();
        finishTest("reset state", c0, e0);

        // Isolated strobes with operands loaded by LI
        c0 = checkCount;
        e0 = errorCount;
        for (k = 0; k < 10; k++) begin
            issue(10, 1, 0, 0, takeBits(6), "independent ops");
            idle(3);
            issue(10, 2, 0, 0, takeBits(6), "independent ops");
            idle(3);
            issue(legalOp(k), 3, 1, 2, takeBits(6), "independent ops");
            idle(3);
        end
        waitDrain();
        finishTest("independent ops", c0, e0);

        // Each instruction reads the previous destination through rs or rt
        c0 = checkCount;
        e0 = errorCount;
        prevRd = 3;
        for (k = 0; k < 16; k++) begin
            rd = 1 + takeBits(2) % 3;
            other = takeBits(2);
            if (k % 2 == 0) begin
                issue(legalOp(takeBits(4) % 10), rd, prevRd, other, takeBits(6), "back-to-back");
            end else begin
                issue(legalOp(takeBits(3) % 7), rd, other, prevRd, 0, "back-to-back");
            end
            prevRd = rd;
        end
        waitDrain();
        finishTest("back-to-back", c0, e0);

        // Destinations alternate r4 and r5 so the dependence skips one slot
        c0 = checkCount;
        e0 = errorCount;
        for (k = 0; k < 16; k++) begin
            rd = 4 + k % 2;
            other = 1 + takeBits(2) % 3;
            if (k % 2 == 0) begin
                issue(legalOp(takeBits(4) % 10), rd, rd, other, takeBits(6), "distance two");
            end else begin
                issue(legalOp(takeBits(3) % 7), rd, other, rd, 0, "distance two");
            end
        end
        waitDrain();
        finishTest("distance two", c0, e0);

        // Illegal slot followed by a read of the would-be destination
        c0 = checkCount;
        e0 = errorCount;
        for (k = 0; k < 4; k++) begin
            issue(10, k + 1, 0, 0, takeBits(6), "illegal opcodes");
            idle(3);
            issue(illegalOp(takeBits(3) % 6), k + 1, k + 1, k + 1, takeBits(6),
                  "illegal opcodes");
            idle(3);
            issue(3, k + 1, k + 1, 0, 0, "illegal opcodes");
            idle(3);
        end
        waitDrain();
        finishTest("illegal opcodes", c0, e0);

        c0 = checkCount;
        e0 = errorCount;
        for (k = 0; k < randomSlots; k++) begin
            if (takeBits(1) == 1) begin
                issue(randomOp(), takeBits(2), takeBits(2), takeBits(2), takeBits(6),
                      "random run");
            end else begin
                idle(1);
            end
        end
        waitDrain();
        finishTest("random run", c0, e0);

        c0 = checkCount;
        e0 = errorCount;
        @(negedge clk);
        checkValue("retire count", "retireCount", legalIssued, retireCount);
        finishTest("retire count", c0, e0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors", testsRun, testsFailed,
                 checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== design/core.sv ====
// Three-stage core top
`timescale 1ns/1ps
`include "core_consts.svh"

module core (
    input  logic                        clk,
    input  logic                        reset,
    input  core_pkg::coreInstr          instr,
    input  logic                        instrValid,
    output logic                        retireValid,
    output logic [`CORE_REG_BITS-1:0]   retireReg,
    output logic [`CORE_DATA_WIDTH-1:0] retireData,
    output logic                        err,
    output logic [`CORE_DATA_WIDTH-1:0] retireCount
);

    logic [`CORE_REG_BITS-1:0]   rsAddr, rtAddr;
    logic [`CORE_DATA_WIDTH-1:0] rsData, rtData;
    logic                        decValid, decIllegal;
    core_pkg::coreOp             decOp;
    logic [`CORE_REG_BITS-1:0]   decRd, decRs, decRt;
    logic [`CORE_DATA_WIDTH-1:0] decA, decB;
    logic                        exValid, exIllegal;
    logic [`CORE_REG_BITS-1:0]   exRd;
    logic [`CORE_DATA_WIDTH-1:0] exData;

    decode decode0 (.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .decValid(decValid), .decIllegal(decIllegal), .decOp(decOp), .decRd(decRd),
        .decRs(decRs), .decRt(decRt), .decA(decA), .decB(decB));

    execute execute0 (.clk(clk), .reset(reset), .decValid(decValid),
        .decIllegal(decIllegal), .decOp(decOp), .decRd(decRd), .decRs(decRs),
        .decRt(decRt), .decA(decA), .decB(decB), .exValid(exValid),
        .exIllegal(exIllegal), .exRd(exRd), .exData(exData));

    result result0 (.clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .rsData(rsData), .rtData(rtData), .exValid(exValid), .exIllegal(exIllegal),
        .exRd(exRd), .exData(exData), .retireCount(retireCount));

    // Retire slot seen from outside
    assign retireValid = exValid && !exIllegal;
    assign err         = exValid && exIllegal;
    assign retireReg   = exRd;
    assign retireData  = exData;

endmodule

// ==== design/core_pkg.sv ====
// Core instruction types
`include "core_consts.svh"

package core_pkg;

    // Opcodes 7 and 11 to 15 are illegal
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opSll  = 4'd5,
        opSrl  = 4'd6,
        opAddi = 4'd8,
        opXori = 4'd9,
        opLi   = 4'd10
    } coreOp;

    // Register format
    typedef struct packed {
        coreOp                     opcode;
        logic [`CORE_REG_BITS-1:0] rd;
        logic [`CORE_REG_BITS-1:0] rs;
        logic [`CORE_REG_BITS-1:0] rt;
        logic [2:0]                unused;
    } coreRType;

    // Immediate format
    typedef struct packed {
        coreOp                            opcode;
        logic [`CORE_REG_BITS-1:0]        rd;
        logic [`CORE_REG_BITS-1:0]        rs;
        logic signed [`CORE_IMM_BITS-1:0] imm;
    } coreIType;

    typedef union packed {
        coreRType r;
        coreIType i;
    } coreInstr;

endpackage

// ==== design/decode.sv ====
// Decode stage
`timescale 1ns/1ps
`include "core_consts.svh"

module decode (
    input  logic                        clk,
    input  logic                        reset,
    input  core_pkg::coreInstr          instr,
    input  logic                        instrValid,
    output logic [`CORE_REG_BITS-1:0]   rsAddr,
    output logic [`CORE_REG_BITS-1:0]   rtAddr,
    input  logic [`CORE_DATA_WIDTH-1:0] rsData,
    input  logic [`CORE_DATA_WIDTH-1:0] rtData,
    output logic                        decValid,
    output logic                        decIllegal,
    output core_pkg::coreOp             decOp,
    output logic [`CORE_REG_BITS-1:0]   decRd,
    output logic [`CORE_REG_BITS-1:0]   decRs,
    output logic [`CORE_REG_BITS-1:0]   decRt,
    output logic [`CORE_DATA_WIDTH-1:0] decA,
    output logic [`CORE_DATA_WIDTH-1:0] decB
);

    logic                        isRFormat;
    logic                        isIFormat;
    logic [`CORE_DATA_WIDTH-1:0] immExt;
    logic [`CORE_DATA_WIDTH-1:0] operandB;

    // Register fields share their position in both formats
    assign rsAddr = instr.r.rs;
    assign rtAddr = instr.r.rt;

    // Opcode class
    always_comb begin
        case (instr.r.opcode)
            core_pkg::opAdd, core_pkg::opSub, core_pkg::opAnd, core_pkg::opOr,
            core_pkg::opXor, core_pkg::opSll, core_pkg::opSrl: begin
                isRFormat = 1'b1;
                isIFormat = 1'b0;
            end
            core_pkg::opAddi, core_pkg::opXori, core_pkg::opLi: begin
                isRFormat = 1'b0;
                isIFormat = 1'b1;
            end
            default: begin
                isRFormat = 1'b0;
                isIFormat = 1'b0;
            end
        endcase
    end

    // Immediate view of the same word
    assign immExt = {{(`CORE_DATA_WIDTH - `CORE_IMM_BITS){instr.i.imm[`CORE_IMM_BITS-1]}},
                     instr.i.imm};

    assign operandB = isIFormat ? immExt : rtData;

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid   <= 1'b0;
            decIllegal <= 1'b0;
        end else begin
            decValid   <= instrValid;
            decIllegal <= instrValid && !(isRFormat || isIFormat);
        end
    end

    // Fields only move on a strobe
    always_ff @(posedge clk) begin
        if (instrValid) begin
            decOp <= instr.r.opcode;
            decRd <= instr.r.rd;
            decRs <= instr.r.rs;
            decRt <= instr.r.rt;
            decA  <= rsData;
            decB  <= operandB;
        end
    end

endmodule

// ==== design/execute.sv ====
// Execute stage
`timescale 1ns/1ps
`include "core_consts.svh"

module execute (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        decValid,
    input  logic                        decIllegal,
    input  core_pkg::coreOp             decOp,
    input  logic [`CORE_REG_BITS-1:0]   decRd,
    input  logic [`CORE_REG_BITS-1:0]   decRs,
    input  logic [`CORE_REG_BITS-1:0]   decRt,
    input  logic [`CORE_DATA_WIDTH-1:0] decA,
    input  logic [`CORE_DATA_WIDTH-1:0] decB,
    output logic                        exValid,
    output logic                        exIllegal,
    output logic [`CORE_REG_BITS-1:0]   exRd,
    output logic [`CORE_DATA_WIDTH-1:0] exData
);

    logic                        isRFormat;
    logic                        exWrites;
    logic                        fwdA;
    logic                        fwdB;
    logic [`CORE_DATA_WIDTH-1:0] opA;
    logic [`CORE_DATA_WIDTH-1:0] opB;
    logic [`CORE_DATA_WIDTH-1:0] aluOut;

    // I-format carries the immediate in decB, never rt
    assign isRFormat = decOp inside {core_pkg::opAdd, core_pkg::opSub, core_pkg::opAnd,
                                     core_pkg::opOr, core_pkg::opXor, core_pkg::opSll,
                                     core_pkg::opSrl};

    // Previous instruction still in flight to the register file
    assign exWrites = exValid && !exIllegal;
    assign fwdA     = exWrites && (exRd == decRs);
    assign fwdB     = exWrites && isRFormat && (exRd == decRt);

    assign opA = fwdA ? exData : decA;
    assign opB = fwdB ? exData : decB;

    always_comb begin
        case (decOp)
            core_pkg::opAdd, core_pkg::opAddi: aluOut = opA + opB;
            core_pkg::opSub:                   aluOut = opA - opB;
            core_pkg::opAnd:                   aluOut = opA & opB;
            core_pkg::opOr:                    aluOut = opA | opB;
            core_pkg::opXor, core_pkg::opXori: aluOut = opA ^ opB;
            // Shift amount is the low four bits
            core_pkg::opSll:                   aluOut = opA << opB[3:0];
            core_pkg::opSrl:                   aluOut = opA >> opB[3:0];
            core_pkg::opLi:                    aluOut = opB;
            default:                           aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid   <= 1'b0;
            exIllegal <= 1'b0;
        end else begin
            exValid   <= decValid;
            exIllegal <= decValid && decIllegal;
        end
    end

    // Retire slot payload
    always_ff @(posedge clk) begin
        if (decValid) begin
            exRd   <= decRd;
            exData <= aluOut;
        end
    end

endmodule

// ==== design/result.sv ====
// Register file and retire counter
`timescale 1ns/1ps
`include "core_consts.svh"

module result (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`CORE_REG_BITS-1:0]   rsAddr,
    input  logic [`CORE_REG_BITS-1:0]   rtAddr,
    output logic [`CORE_DATA_WIDTH-1:0] rsData,
    output logic [`CORE_DATA_WIDTH-1:0] rtData,
    input  logic                        exValid,
    input  logic                        exIllegal,
    input  logic [`CORE_REG_BITS-1:0]   exRd,
    input  logic [`CORE_DATA_WIDTH-1:0] exData,
    output logic [`CORE_DATA_WIDTH-1:0] retireCount
);

    logic [`CORE_DATA_WIDTH-1:0] regFile [`CORE_REG_COUNT];
    logic                        writeEn;

    // Illegal slots never write back
    assign writeEn = exValid && !exIllegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeEn) begin
            regFile[exRd] <= exData;
        end
    end

    // Write-through covers the distance-two dependence
    assign rsData = (writeEn && (exRd == rsAddr)) ? exData : regFile[rsAddr];
    assign rtData = (writeEn && (exRd == rtAddr)) ? exData : regFile[rtAddr];

    always_ff @(posedge clk) begin
        if (reset) begin
            retireCount <= '0;
        end else if (writeEn) begin
            retireCount <= retireCount + 1'b1;
        end
    end

endmodule

// ==== include/core_consts.svh ====
// Core width constants
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path and register file word
`define CORE_DATA_WIDTH 16

// General register count
`define CORE_REG_COUNT 8

// Register address field
`define CORE_REG_BITS 3

// Immediate field of the I-format, sign-extended in decode
`define CORE_IMM_BITS 6

`endif

// ==== list.f ====
+incdir+include
design/core_pkg.sv
design/decode.sv
design/execute.sv
design/result.sv
design/core.sv
bench/core_properties.sv
bench/core_tb.sv
